/* verilog/miniAluPkg.sv */
package miniAluPkg;

	//**************************************************************************
	// Widths and sizes.
	//**************************************************************************
	localparam int WORD_WIDTH       = 16;
	localparam int REG_ADDR_WIDTH   = 8;
	localparam int INSTR_ADDR_WIDTH = 16;
	localparam int KEY_WIDTH        = 8;
	localparam int LED_WIDTH        = 8;
	localparam int RAM_DEPTH        = 256;
	localparam int ROM_DEPTH        = 16;  // Program words in the ROM.
	localparam int PS2_DATA_BITS    = 8;   // Data bits per PS/2 frame.

	typedef logic signed [WORD_WIDTH-1:0] word_t;
	typedef logic [REG_ADDR_WIDTH-1:0]    regAddr_t;
	typedef logic [INSTR_ADDR_WIDTH-1:0]  instrAddr_t;
	typedef logic [KEY_WIDTH-1:0]         keyCode_t;
	typedef logic [LED_WIDTH-1:0]         ledByte_t;

	//**************************************************************************
	// Instruction set.
	//**************************************************************************
	// Codes 12 to 15 are unused and execute as NOP.
	typedef enum logic [3:0]
	{
		NOP          = 4'd0,
		ADD          = 4'd1,
		SUB          = 4'd2,
		SMUL         = 4'd3,
		STO          = 4'd4,
		BLE          = 4'd5,
		JMP          = 4'd6,
		LED          = 4'd7,
		CALL         = 4'd8,
		RET          = 4'd9,
		BRANCH_IF_KB = 4'd10,
		KEY          = 4'd11
	} opcode_t;

	// 28-bit word: op [27:24], dest [23:16], src1 [15:8], src0 [7:0].
	typedef struct packed
	{
		opcode_t  op;
		regAddr_t dest;
		regAddr_t src1;
		regAddr_t src0;
	} instr_t;

	// PS/2 frame receiver states.
	typedef enum logic [1:0]
	{
		IDLE   = 2'd0,
		DATA   = 2'd1,
		PARITY = 2'd2,
		STOP   = 2'd3
	} ps2State_t;

endpackage

/* verilog/instructionRom.sv */
`timescale 1ns/10ps
module instructionRom
(
	input  miniAluPkg::instrAddr_t ip,
	output miniAluPkg::instr_t     instr
);

	// Fields are op, dest, src1, src0. STO takes its immediate from {src1, src0}.
	// Two-operand ops compute src1 op src0, and BLE tests src1 <= src0.
	always_comb
	begin
		instr = '{miniAluPkg::NOP, 8'd0, 8'd0, 8'd0};
		if (ip < miniAluPkg::ROM_DEPTH)
		begin
			case (ip)
				// Constants.
				16'd0:  instr = '{miniAluPkg::STO, 8'd3, 8'd0, 8'd3};
				16'd1:  instr = '{miniAluPkg::STO, 8'd4, 8'd0, 8'd5};
				16'd2:  instr = '{miniAluPkg::STO, 8'd5, 8'd0, 8'd200};
				16'd3:  instr = '{miniAluPkg::STO, 8'd6, 8'd0, 8'd1};

				// Spin here until a key is pending.
				16'd4:  instr = '{miniAluPkg::BRANCH_IF_KB, 8'd4, 8'd0, 8'd0};
				16'd5:  instr = '{miniAluPkg::KEY, 8'd1, 8'd0, 8'd0};

				// r2 = 3 * key - 5, less 200 when above 200.
				16'd6:  instr = '{miniAluPkg::SMUL, 8'd2, 8'd1, 8'd3};
				16'd7:  instr = '{miniAluPkg::SUB, 8'd2, 8'd2, 8'd4};
				16'd8:  instr = '{miniAluPkg::BLE, 8'd10, 8'd2, 8'd5};
				16'd9:  instr = '{miniAluPkg::SUB, 8'd2, 8'd2, 8'd5};

				16'd10: instr = '{miniAluPkg::CALL, 8'd13, 8'd0, 8'd0};
				16'd11: instr = '{miniAluPkg::LED, 8'd0, 8'd0, 8'd2};  // Show r2.
				16'd12: instr = '{miniAluPkg::JMP, 8'd4, 8'd0, 8'd0};

				// Increment subroutine.
				16'd13: instr = '{miniAluPkg::ADD, 8'd2, 8'd2, 8'd6};
				16'd14: instr = '{miniAluPkg::RET, 8'd0, 8'd0, 8'd0};

				default: instr = '{miniAluPkg::NOP, 8'd0, 8'd0, 8'd0};
			endcase
		end
	end

endmodule

/* verilog/dataRam.sv */
`timescale 1ns/10ps
module dataRam
(
	input  logic                 Clock,
	input  logic                 wrEn,
	input  miniAluPkg::regAddr_t wrAddr,
	input  miniAluPkg::word_t    wrData,
	input  miniAluPkg::regAddr_t rdAddr0,
	input  miniAluPkg::regAddr_t rdAddr1,
	output miniAluPkg::word_t    rdData0,
	output miniAluPkg::word_t    rdData1
);

	miniAluPkg::word_t mem [miniAluPkg::RAM_DEPTH];

	always_ff @(posedge Clock)
	begin
		if (wrEn)
			mem[wrAddr] <= wrData;
	end

	// A write in flight is passed straight to a matching read port, so the
	// instruction right behind the writer sees the new value.
	assign rdData0 = (wrEn && (wrAddr == rdAddr0)) ? wrData : mem[rdAddr0];
	assign rdData1 = (wrEn && (wrAddr == rdAddr1)) ? wrData : mem[rdAddr1];

endmodule

/* verilog/ps2Receiver.sv */
`timescale 1ns/10ps
module ps2Receiver
(
	input  logic                 Clock,
	input  logic                 rstN,
	input  logic                 ps2Clk,
	input  logic                 ps2Data,
	output miniAluPkg::keyCode_t keyCode,
	output logic                 keyStrobe
);

	logic [1:0] clkSync;   // Bit 1 is the synchronized PS/2 clock.
	logic [1:0] dataSync;  // Same depth, so data lines up with the clock.
	logic       clkPrev;
	logic       fallEdge;

	miniAluPkg::ps2State_t                        state;
	logic [$clog2(miniAluPkg::PS2_DATA_BITS)-1:0] bitCount;
	miniAluPkg::keyCode_t                         shiftReg;
	logic                                         parityBit;

	// Both lines idle high.
	always_ff @(posedge Clock)
	begin
		if (!rstN)
		begin
			clkSync  <= 2'b11;
			dataSync <= 2'b11;
			clkPrev  <= 1'b1;
		end
		else
		begin
			clkSync  <= {clkSync[0], ps2Clk};
			dataSync <= {dataSync[0], ps2Data};
			clkPrev  <= clkSync[1];
		end
	end

	assign fallEdge = clkPrev & ~clkSync[1];

	//**************************************************************************
	// Frame FSM, advancing on each falling edge of the PS/2 clock.
	//**************************************************************************
	always_ff @(posedge Clock)
	begin
		if (!rstN)
		begin
			state     <= miniAluPkg::IDLE;
			bitCount  <= '0;
			keyStrobe <= 1'b0;
		end
		else
		begin
			keyStrobe <= 1'b0;
			if (fallEdge)
			begin
				case (state)
					miniAluPkg::IDLE:
					begin
						if (!dataSync[1])  // Start bit.
						begin
							state    <= miniAluPkg::DATA;
							bitCount <= '0;
						end
					end
					miniAluPkg::DATA:
					begin
						bitCount <= bitCount + 1'b1;
						if (bitCount == miniAluPkg::PS2_DATA_BITS - 1)
							state <= miniAluPkg::PARITY;
					end
					miniAluPkg::PARITY:
						state <= miniAluPkg::STOP;
					default:
					begin
						// Odd parity over data and parity bit, stop bit high.
						state     <= miniAluPkg::IDLE;
						keyStrobe <= dataSync[1] & (^{parityBit, shiftReg});
					end
				endcase
			end
		end
	end

	// Data arrives LSB first.
	always_ff @(posedge Clock)
	begin
		if (fallEdge && (state == miniAluPkg::DATA))
			shiftReg <= {dataSync[1], shiftReg[miniAluPkg::KEY_WIDTH-1:1]};
		if (fallEdge && (state == miniAluPkg::PARITY))
			parityBit <= dataSync[1];
	end

	assign keyCode = shiftReg;  // Stable while keyStrobe is high.

endmodule

/* verilog/ioRegisters.sv */
`timescale 1ns/10ps
module ioRegisters
(
	input  logic                 Clock,
	input  logic                 rstN,
	input  miniAluPkg::keyCode_t keyCode,
	input  logic                 keyStrobe,
	input  logic                 keyTake,
	output miniAluPkg::keyCode_t heldKey,
	output logic                 keyReady,
	input  logic                 ledLoad,
	input  miniAluPkg::ledByte_t ledData,
	output miniAluPkg::ledByte_t led,
	output logic                 ledStrobe
);

	// Pending key. A fresh key beats a take in the same cycle.
	always_ff @(posedge Clock)
	begin
		if (!rstN)
			keyReady <= 1'b0;
		else if (keyStrobe)
			keyReady <= 1'b1;
		else if (keyTake)
			keyReady <= 1'b0;
	end

	always_ff @(posedge Clock)
	begin
		if (keyStrobe)
			heldKey <= keyCode;  // Later key overwrites an untaken one.
	end

	// LED register and its update pulse.
	always_ff @(posedge Clock)
	begin
		if (!rstN)
		begin
			led       <= '0;
			ledStrobe <= 1'b0;
		end
		else
		begin
			ledStrobe <= ledLoad;  // High in the cycle the new value shows.
			if (ledLoad)
				led <= ledData;
		end
	end

endmodule

/* verilog/miniAlu.sv */
`timescale 1ns/10ps
module miniAlu
(
	input  logic                 Clock,
	input  logic                 rstN,
	input  logic                 ps2Clk,
	input  logic                 ps2Data,
	output miniAluPkg::ledByte_t led,
	output logic                 ledStrobe
);

	miniAluPkg::instrAddr_t ip;
	miniAluPkg::instrAddr_t ipCounter;     // Sequential fetch address.
	miniAluPkg::instrAddr_t retAddr;       // Single return register.
	miniAluPkg::instrAddr_t branchTarget;
	miniAluPkg::instr_t     instr;
	miniAluPkg::instr_t     exec;          // Instruction now executing.

	miniAluPkg::word_t rdData0;
	miniAluPkg::word_t rdData1;
	miniAluPkg::word_t opA0;               // Operands captured with exec.
	miniAluPkg::word_t opA1;
	miniAluPkg::word_t result;
	logic signed [2*miniAluPkg::WORD_WIDTH-1:0] product;

	miniAluPkg::keyCode_t keyCode;
	miniAluPkg::keyCode_t heldKey;
	logic keyStrobe;
	logic keyReady;
	logic keyTake;
	logic ledLoad;
	logic wrEn;
	logic branchTaken;

	//**************************************************************************
	// Fetch.
	//**************************************************************************
	assign branchTarget = (exec.op == miniAluPkg::RET) ? retAddr :
		miniAluPkg::instrAddr_t'(exec.dest);
	assign ip = branchTaken ? branchTarget : ipCounter;

	instructionRom instructionRom
	(
		.ip(    ip    ),
		.instr( instr )
	);

	// The ROM word's sources address the RAM ahead of execution.
	dataRam dataRam
	(
		.Clock(   Clock      ),
		.wrEn(    wrEn       ),
		.wrAddr(  exec.dest  ),
		.wrData(  result     ),
		.rdAddr0( instr.src0 ),
		.rdAddr1( instr.src1 ),
		.rdData0( rdData0    ),
		.rdData1( rdData1    )
	);

	always_ff @(posedge Clock)
	begin
		if (!rstN)
		begin
			ipCounter <= '0;
			exec      <= '{op: miniAluPkg::NOP, dest: '0, src1: '0, src0: '0};
			retAddr   <= '0;
		end
		else
		begin
			ipCounter <= ip + 1'b1;
			exec      <= instr;
			if (exec.op == miniAluPkg::CALL)
				retAddr <= ipCounter;  // Counter already points past the CALL.
		end
	end

	always_ff @(posedge Clock)
	begin
		opA0 <= rdData0;
		opA1 <= rdData1;
	end

	//**************************************************************************
	// Execute.
	//**************************************************************************
	assign product = opA1 * opA0;

	always_comb
	begin
		result      = '0;
		wrEn        = 1'b0;
		branchTaken = 1'b0;
		keyTake     = 1'b0;
		ledLoad     = 1'b0;
		case (exec.op)
			miniAluPkg::ADD:
			begin
				result = opA1 + opA0;
				wrEn   = 1'b1;
			end
			miniAluPkg::SUB:
			begin
				result = opA1 - opA0;
				wrEn   = 1'b1;
			end
			miniAluPkg::SMUL:
			begin
				result = product[miniAluPkg::WORD_WIDTH-1:0];  // Low half only.
				wrEn   = 1'b1;
			end
			miniAluPkg::STO:
			begin
				result = {exec.src1, exec.src0};
				wrEn   = 1'b1;
			end
			miniAluPkg::BLE:
				branchTaken = (opA1 <= opA0);  // Signed compare.
			miniAluPkg::JMP, miniAluPkg::CALL, miniAluPkg::RET:
				branchTaken = 1'b1;
			miniAluPkg::BRANCH_IF_KB:
				branchTaken = !keyReady;
			miniAluPkg::KEY:
			begin
				result  = {{(miniAluPkg::WORD_WIDTH-miniAluPkg::KEY_WIDTH){1'b0}}, heldKey};
				wrEn    = 1'b1;
				keyTake = 1'b1;
			end
			miniAluPkg::LED:
				ledLoad = 1'b1;
			default:
				result = '0;  // NOP and unused codes.
		endcase
	end

	//**************************************************************************
	// Keyboard and LED.
	//**************************************************************************
	ps2Receiver ps2Receiver
	(
		.Clock(     Clock     ),
		.rstN(      rstN      ),
		.ps2Clk(    ps2Clk    ),
		.ps2Data(   ps2Data   ),
		.keyCode(   keyCode   ),
		.keyStrobe( keyStrobe )
	);

	ioRegisters ioRegisters
	(
		.Clock(     Clock                           ),
		.rstN(      rstN                            ),
		.keyCode(   keyCode                         ),
		.keyStrobe( keyStrobe                       ),
		.keyTake(   keyTake                         ),
		.heldKey(   heldKey                         ),
		.keyReady(  keyReady                        ),
		.ledLoad(   ledLoad                         ),
		.ledData(   opA0[miniAluPkg::LED_WIDTH-1:0] ),
		.led(       led                             ),
		.ledStrobe( ledStrobe                       )
	);

endmodule

/* test/clockGen.sv */
`timescale 1ns/10ps
module clockGen
(
	output logic Clock
);

	initial
		Clock = 1'b0;

	always #20 Clock = ~Clock;  // 40 ns period.

endmodule

/* test/miniAlu_asserts.sv */
`timescale 1ns/10ps
module miniAlu_asserts
(
	input logic                   Clock,
	input logic                   rstN,
	input logic                   wrEn,
	input logic                   ledStrobe,
	input miniAluPkg::instrAddr_t ip,
	input logic                   keyStrobe,
	input logic                   keyTake,
	input logic                   keyReady
);

	int failures = 0;  // Count of failed assertions.

	assert property (@(posedge Clock) !rstN |=> (!ledStrobe && !wrEn))
	else
	begin
		failures++;
		$error("ledStrobe or wrEn high in the cycle after a reset edge");
	end

	// The program never runs off the end of the ROM.
	assert property (@(posedge Clock) disable iff (!rstN) ip < miniAluPkg::ROM_DEPTH)
	else
	begin
		failures++;
		$error("instruction pointer %0d outside the ROM", ip);
	end

	assert property (@(posedge Clock) disable iff (!rstN) (keyTake && !keyStrobe) |=> !keyReady)
	else
	begin
		failures++;
		$error("keyReady still set after a KEY take");
	end

	assert property (@(posedge Clock) disable iff (!rstN) ledStrobe |=> !ledStrobe)
	else
	begin
		failures++;
		$error("ledStrobe high for two cycles");
	end

endmodule

bind miniAlu miniAlu_asserts asserts (.*);

/* test/miniAluTb.sv */
`timescale 1ns/10ps
module miniAluTb;

	localparam int FRAME_LIMIT   = 300;                   // Cycles budgeted per frame.
	localparam int TIMEOUT_LIMIT = 12 * FRAME_LIMIT + 500;
	localparam int HALF_BIT      = 8;                     // PS/2 half period in Clocks.
	localparam int STROBE_WAIT   = 100;

	logic                 Clock;
	logic                 rstN;
	logic                 ps2Clk;
	logic                 ps2Data;
	miniAluPkg::ledByte_t led;
	logic                 ledStrobe;

	integer               seed;
	int                   cycleCount  = 0;
	int                   strobeCount = 0;
	int                   strobeMark;
	miniAluPkg::ledByte_t lastLed;
	int                   testErrors;
	int                   passCount;
	int                   failCount;

	clockGen clockGen (.Clock(Clock));

	miniAlu uut
	(
		.Clock(     Clock     ),
		.rstN(      rstN      ),
		.ps2Clk(    ps2Clk    ),
		.ps2Data(   ps2Data   ),
		.led(       led       ),
		.ledStrobe( ledStrobe )
	);

	// Strobe monitor, sampled mid-cycle.
	always @(negedge Clock)
	begin
		if (ledStrobe)
		begin
			strobeCount = strobeCount + 1;
			lastLed     = led;
		end
	end

	always @(posedge Clock)
	begin
		cycleCount = cycleCount + 1;
		if (cycleCount >= TIMEOUT_LIMIT)
		begin
			$display("Timeout: the run went past %0d cycles", TIMEOUT_LIMIT);
			$display("RESULT: FAIL");
			$finish;
		end
	end

	//**************************************************************************
	// Reference model and helpers.
	//**************************************************************************
	// LED byte for key k: v = 3k - 5, less 200 above 200, plus 1.
	function automatic miniAluPkg::ledByte_t expectedLed(input miniAluPkg::keyCode_t key);
		int v;
		v = 3 * int'(key) - 5;
		if (v > 200)
			v = v - 200;
		v = v + 1;
		return v[7:0];
	endfunction

	task automatic stepCycles(input int n);
		repeat (n) @(posedge Clock);
		#5;
	endtask

	// Start, eight data bits LSB first, parity, stop.
	task automatic sendFrame(input miniAluPkg::keyCode_t key, input bit goodParity);
		logic [10:0] frame;
		frame = {1'b1, (goodParity ? ~^key : ^key), key, 1'b0};
		for (int i = 0; i < 11; i++)
		begin
			ps2Data = frame[i];
			stepCycles(HALF_BIT);
			ps2Clk = 1'b0;  // Receiver samples on this edge.
			stepCycles(HALF_BIT);
			ps2Clk = 1'b1;
		end
	endtask

	task automatic checkLed(input string name, input miniAluPkg::ledByte_t expected,
		input miniAluPkg::ledByte_t actual);
		if (actual !== expected)
		begin
			$display("** Error %s: expected 8'h%02h, actual 8'h%02h", name, expected, actual);
			testErrors++;
		end
	endtask

	task automatic checkAddr(input string name, input miniAluPkg::instrAddr_t expected,
		input miniAluPkg::instrAddr_t actual);
		if (actual !== expected)
		begin
			$display("** Error %s: expected ip %0d, actual ip %0d", name, expected, actual);
			testErrors++;
		end
	endtask

	task automatic checkNoStrobe(input string name);
		if (strobeCount != strobeMark)
		begin
			$display("%s: the LED strobe rose although no key result was due", name);
			testErrors++;
		end
	endtask

	// Send one good key and compare the LED byte it produces.
	task automatic runKey(input string name, input miniAluPkg::keyCode_t key);
		int waited;
		waited     = 0;
		strobeMark = strobeCount;
		sendFrame(key, 1'b1);
		while ((strobeCount == strobeMark) && (waited < STROBE_WAIT))
		begin
			stepCycles(1);
			waited++;
		end
		if (strobeCount == strobeMark)
		begin
			$display("%s: no LED strobe for key 8'h%02h", name, key);
			testErrors++;
		end
		else
			checkLed(name, expectedLed(key), lastLed);
	endtask

	task automatic endTest(input string name);
		if (testErrors == 0)
		begin
			$display("Test %s passed", name);
			passCount++;
		end
		else
		begin
			$display("Test %s failed with %0d errors", name, testErrors);
			failCount++;
		end
		testErrors = 0;
	endtask

	//**************************************************************************
	// Directed tests.
	//**************************************************************************
	initial
	begin
		miniAluPkg::keyCode_t key;
		rstN       = 1'b0;
		ps2Clk     = 1'b1;
		ps2Data    = 1'b1;
		seed       = 32'hf626a97d;
		testErrors = 0;
		passCount  = 0;
		failCount  = 0;
		stepCycles(4);
		rstN = 1'b1;

		// Idle after reset, spinning on BRANCH_IF_KB.
		checkLed("reset", '0, led);
		strobeMark = strobeCount;
		stepCycles(200);
		checkNoStrobe("reset");
		checkAddr("reset", 16'd4, uut.ip);
		endTest("reset");

		runKey("small key", 8'h10);
		endTest("small key");

		runKey("clamp", 8'h50);
		runKey("clamp negative", 8'h00);
		endTest("clamp");

		strobeMark = strobeCount;
		sendFrame(8'h21, 1'b0);
		stepCycles(FRAME_LIMIT);
		checkNoStrobe("bad parity");
		runKey("bad parity", 8'h21);
		endTest("bad parity");

		for (int n = 0; n < 8; n++)
		begin
			key = miniAluPkg::keyCode_t'($random(seed));
			runKey($sformatf("random 8'h%02h", key), key);
		end
		endTest("random");

		$display("Tests passed: %0d, failed: %0d, assertion failures: %0d",
			passCount, failCount, uut.asserts.failures);
		if ((failCount == 0) && (uut.asserts.failures == 0))
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

/* miniAlu.f */
verilog/miniAluPkg.sv
verilog/instructionRom.sv
verilog/dataRam.sv
verilog/ps2Receiver.sv
verilog/ioRegisters.sv
verilog/miniAlu.sv
test/clockGen.sv
test/miniAlu_asserts.sv
test/miniAluTb.sv
